/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Register and pc width
  localparam int XLEN = 64;
  // Instruction word width
  localparam int ILEN = 32;

  // Major opcodes of the RV64I base set
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // funct7 of ADD/SRL and of SUB/SRA
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

endpackage

/* rtl/exu_pkg.sv */
package exu_pkg;

  // Execute info word and its group field
  localparam int INFO_W = 15;
  localparam int GRP_W  = 3;

  // ALU and no-op share code 0, no-op has no op bit set
  localparam logic [GRP_W-1:0] GRP_NONE = 3'd0;
  localparam logic [GRP_W-1:0] GRP_ALU  = 3'd0;
  localparam logic [GRP_W-1:0] GRP_BJP  = 3'd1;

  // ALU view, one-hot op bits above the group
  typedef struct packed {
    logic ebreak;
    logic lui;
    logic and_;
    logic or_;
    logic sra;
    logic srl;
    logic xor_;
    logic sltu;
    logic slt;
    logic sll;
    logic sub;
    logic add;
    logic [GRP_W-1:0] group;
  } alu_info_t;

  // Branch/jump view, spare bits fill up to the word width
  typedef struct packed {
    logic [INFO_W-GRP_W-9:0] spare;
    logic bgeu;
    logic bltu;
    logic bge;
    logic blt;
    logic bne;
    logic beq;
    logic jalr;
    logic jal;
    logic [GRP_W-1:0] group;
  } bjp_info_t;

  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } exu_info_u;

  // Instruction queue entries
  localparam int IQ_DEPTH = 2;

endpackage

/* rtl/ifu_fetch.sv */
module ifu_fetch import rv_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            q_room_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic [ILEN-1:0] wb_dat_i,
  input  logic            wb_ack_i,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic [XLEN-1:0] wb_adr_o,
  output logic            push_o,
  output logic            push_pc_o_unused_guard,
  output logic [XLEN-1:0] push_pc_o,
  output logic [ILEN-1:0] push_inst_o
);

  // Next address to request
  logic [XLEN-1:0] pc_q;
  // Open cycle, the waiting-for-ack state
  logic cyc_q;
  // Open cycle was overtaken by a redirect
  logic kill_q;
  logic start;

  // Only one request open, and only with room in the queue
  assign start = ~cyc_q & q_room_i & ~redirect_i;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;

  // Killed acks and acks under a redirect are dropped
  assign push_o      = cyc_q & wb_ack_i & ~kill_q & ~redirect_i;
  assign push_pc_o   = wb_adr_o;
  assign push_inst_o = wb_dat_i;
  assign push_pc_o_unused_guard = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q   <= RESET_PC;
      cyc_q  <= 1'b0;
      kill_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (push_o) begin
        pc_q <= pc_q + XLEN'(4);
      end
      if (cyc_q) begin
        // Ack closes the cycle for at least one clock
        if (wb_ack_i) begin
          cyc_q  <= 1'b0;
          kill_q <= 1'b0;
        end else if (redirect_i) begin
          kill_q <= 1'b1;
        end
      end else if (start) begin
        cyc_q <= 1'b1;
      end
    end
  end

  // Address held steady for the whole cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      wb_adr_o <= pc_q;
    end
  end

endmodule

/* rtl/inst_queue.sv */
module inst_queue import rv_isa_pkg::*, exu_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            push_i,
  input  logic [XLEN-1:0] push_pc_i,
  input  logic [ILEN-1:0] push_inst_i,
  input  logic            pop_i,
  input  logic            flush_i,
  output logic            room_o,
  output logic            valid_o,
  output logic [XLEN-1:0] pc_o,
  output logic [ILEN-1:0] inst_o
);

  localparam int PTR_W = $clog2(IQ_DEPTH);
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  logic [XLEN-1:0] pc_mem   [IQ_DEPTH];
  logic [ILEN-1:0] inst_mem [IQ_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic do_pop;

  // Room leaves a slot for the one fetch that may be in flight
  assign room_o  = count <= CNT_W'(IQ_DEPTH - 1);
  assign valid_o = count != '0;
  assign pc_o    = pc_mem[rd_ptr];
  assign inst_o  = inst_mem[rd_ptr];
  assign do_pop  = pop_i & valid_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop on one edge keep the count
      count <= count + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      pc_mem[wr_ptr]   <= push_pc_i;
      inst_mem[wr_ptr] <= push_inst_i;
    end
  end

endmodule

/* rtl/idu_decode.sv */
module idu_decode import rv_isa_pkg::*, exu_pkg::*; (
  input  logic [ILEN-1:0] inst_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output logic            rd_wr_en_o,
  output logic [4:0]      rs1_idx_o,
  output logic [4:0]      rs2_idx_o,
  output logic [4:0]      rd_idx_o,
  output logic [XLEN-1:0] op1_o,
  output logic [XLEN-1:0] op2_o,
  output logic [XLEN-1:0] op1_jp_o,
  output logic [XLEN-1:0] op2_jp_o,
  output exu_info_u       exu_info_o,
  output logic            invalid_inst_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_r, is_i, is_l, is_s, is_b, is_sys;
  logic jal, jalr, lui, auipc, ebreak;
  logic f7_base, f7_alt, sh_base, sh_alt;
  logic [7:0] f3;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic add, sub, sll, slt, sltu, xor_, srl, sra, or_, and_;
  logic beq, bne, blt, bge, bltu, bgeu;
  logic alu_op, bjp_op;

  assign opcode    = inst_i[6:0];
  assign funct3    = inst_i[14:12];
  assign funct7    = inst_i[31:25];
  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // Major opcode classes
  assign is_r   = opcode == OPC_OP;
  assign is_i   = opcode == OPC_OP_IMM;
  assign is_l   = opcode == OPC_LOAD;
  assign is_s   = opcode == OPC_STORE;
  assign is_b   = opcode == OPC_BRANCH;
  assign is_sys = opcode == OPC_SYSTEM;
  assign jal    = opcode == OPC_JAL;
  assign jalr   = (opcode == OPC_JALR) & f3[0];
  assign lui    = opcode == OPC_LUI;
  assign auipc  = opcode == OPC_AUIPC;
  // EBREAK needs imm 1 with rs1 and rd zero
  assign ebreak = is_sys & f3[0] & (inst_i[31:20] == 12'd1)
                & (rs1_idx_o == 5'd0) & (rd_idx_o == 5'd0);

  // funct3 one-hot
  assign f3 = 8'd1 << funct3;
  assign f7_base = funct7 == F7_BASE;
  assign f7_alt  = funct7 == F7_ALT;
  // RV64 immediate shifts carry a 6-bit shamt
  assign sh_base = inst_i[31:26] == F7_BASE[6:1];
  assign sh_alt  = inst_i[31:26] == F7_ALT[6:1];

  // Immediates
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign imm = ({XLEN{is_i | is_l | jalr}} & imm_i)
             | ({XLEN{is_s}} & imm_s)
             | ({XLEN{is_b}} & imm_b)
             | ({XLEN{jal}} & imm_j)
             | ({XLEN{lui | auipc}} & imm_u);

  // Register and immediate ALU ops
  assign add  = is_r & f3[0] & f7_base | is_i & f3[0] | auipc;
  assign sub  = is_r & f3[0] & f7_alt;
  assign sll  = is_r & f3[1] & f7_base | is_i & f3[1] & sh_base;
  assign slt  = is_r & f3[2] & f7_base | is_i & f3[2];
  assign sltu = is_r & f3[3] & f7_base | is_i & f3[3];
  assign xor_ = is_r & f3[4] & f7_base | is_i & f3[4];
  assign srl  = is_r & f3[5] & f7_base | is_i & f3[5] & sh_base;
  assign sra  = is_r & f3[5] & f7_alt | is_i & f3[5] & sh_alt;
  assign or_  = is_r & f3[6] & f7_base | is_i & f3[6];
  assign and_ = is_r & f3[7] & f7_base | is_i & f3[7];

  // Branches, funct3 2 and 3 are undefined
  assign beq  = is_b & f3[0];
  assign bne  = is_b & f3[1];
  assign blt  = is_b & f3[4];
  assign bge  = is_b & f3[5];
  assign bltu = is_b & f3[6];
  assign bgeu = is_b & f3[7];

  assign alu_op = add | sub | sll | slt | sltu | xor_ | srl | sra | or_ | and_ | lui | ebreak;
  assign bjp_op = jal | jalr | beq | bne | blt | bge | bltu | bgeu;
  assign invalid_inst_o = ~(alu_op | bjp_op);

  // No write for x0, stores, branches, EBREAK or anything undecoded
  assign rd_wr_en_o = (rd_idx_o != 5'd0) & ((alu_op & ~ebreak) | jal | jalr);

  // op1 is rs1, or pc for AUIPC and the jump link
  assign op1_o = ({XLEN{is_r | is_i | is_l | is_s | is_b}} & rs1_data_i)
               | ({XLEN{auipc | jal | jalr}} & pc_i);
  // op2 is rs2, the immediate, or 4 for the link
  assign op2_o = ({XLEN{is_r | is_b}} & rs2_data_i)
               | ({XLEN{is_i | is_l | is_s | lui | auipc}} & imm)
               | ({XLEN{jal | jalr}} & XLEN'(4));

  // Target base and offset
  assign op1_jp_o = ({XLEN{jalr}} & rs1_data_i) | ({XLEN{is_b | jal}} & pc_i);
  assign op2_jp_o = {XLEN{jal | jalr | is_b}} & imm;

  // Fill the view of the decoded group, zero word otherwise
  always_comb begin
    exu_info_o = '0;
    if (bjp_op) begin
      exu_info_o.bjp.group = GRP_BJP;
      exu_info_o.bjp.jal   = jal;
      exu_info_o.bjp.jalr  = jalr;
      exu_info_o.bjp.beq   = beq;
      exu_info_o.bjp.bne   = bne;
      exu_info_o.bjp.blt   = blt;
      exu_info_o.bjp.bge   = bge;
      exu_info_o.bjp.bltu  = bltu;
      exu_info_o.bjp.bgeu  = bgeu;
    end else if (alu_op) begin
      exu_info_o.alu.group  = GRP_ALU;
      exu_info_o.alu.add    = add;
      exu_info_o.alu.sub    = sub;
      exu_info_o.alu.sll    = sll;
      exu_info_o.alu.slt    = slt;
      exu_info_o.alu.sltu   = sltu;
      exu_info_o.alu.xor_   = xor_;
      exu_info_o.alu.srl    = srl;
      exu_info_o.alu.sra    = sra;
      exu_info_o.alu.or_    = or_;
      exu_info_o.alu.and_   = and_;
      exu_info_o.alu.lui    = lui;
      exu_info_o.alu.ebreak = ebreak;
    end else begin
      exu_info_o.alu.group = GRP_NONE;
    end
  end

endmodule

/* rtl/regfile.sv */
module regfile import rv_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            we_i,
  input  logic [4:0]      wa_i,
  input  logic [XLEN-1:0] wd_i,
  input  logic [4:0]      ra1_i,
  input  logic [4:0]      ra2_i,
  output logic [XLEN-1:0] rd1_o,
  output logic [XLEN-1:0] rd2_o
);

  // x1 to x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != 5'd0) begin
      regs[wa_i] <= wd_i;
    end
  end

  assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
  assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule

/* rtl/exu_execute.sv */
module exu_execute import rv_isa_pkg::*, exu_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            q_valid_i,
  input  logic [XLEN-1:0] q_pc_i,
  input  logic [ILEN-1:0] q_inst_i,
  output logic            pop_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic            retire_rd_we_o,
  output logic [4:0]      retire_rd_idx_o,
  output logic [XLEN-1:0] retire_rd_data_o,
  output logic [XLEN-1:0] retire_next_pc_o,
  output logic            ebreak_o,
  output logic            invalid_o,
  output logic [4:0]      rf_ra1_o,
  output logic [4:0]      rf_ra2_o,
  input  logic [XLEN-1:0] rf_rd1_i,
  input  logic [XLEN-1:0] rf_rd2_i,
  output logic            rf_we_o,
  output logic [4:0]      rf_wa_o,
  output logic [XLEN-1:0] rf_wd_o
);

  logic rd_wr_en, invalid;
  logic [XLEN-1:0] op1, op2, op1_jp, op2_jp;
  exu_info_u info;
  alu_info_t a;
  bjp_info_t b;
  logic is_bjp, eq, lt, ltu, taken;
  logic [5:0] shamt;
  logic [XLEN-1:0] sum, alu_res, target;

  idu_decode u_decode (
    .inst_i         (q_inst_i),
    .pc_i           (q_pc_i),
    .rs1_data_i     (rf_rd1_i),
    .rs2_data_i     (rf_rd2_i),
    .rd_wr_en_o     (rd_wr_en),
    .rs1_idx_o      (rf_ra1_o),
    .rs2_idx_o      (rf_ra2_o),
    .rd_idx_o       (rf_wa_o),
    .op1_o          (op1),
    .op2_o          (op2),
    .op1_jp_o       (op1_jp),
    .op2_jp_o       (op2_jp),
    .exu_info_o     (info),
    .invalid_inst_o (invalid)
  );

  // Halted after EBREAK or an undecoded word
  assign pop_o = q_valid_i & ~ebreak_o & ~invalid_o;

  // Group field picks the view
  assign is_bjp = info.bjp.group == GRP_BJP;
  assign a = is_bjp ? alu_info_t'('0) : info.alu;
  assign b = is_bjp ? info.bjp : bjp_info_t'('0);

  // Shared adder also forms the jump link
  assign sum   = op1 + op2;
  assign shamt = op2[5:0];
  assign eq    = op1 == op2;
  assign lt    = $signed(op1) < $signed(op2);
  assign ltu   = op1 < op2;

  assign alu_res = ({XLEN{a.add}} & sum)
                 | ({XLEN{a.sub}} & (op1 - op2))
                 | ({XLEN{a.sll}} & (op1 << shamt))
                 | ({XLEN{a.slt}} & XLEN'(lt))
                 | ({XLEN{a.sltu}} & XLEN'(ltu))
                 | ({XLEN{a.xor_}} & (op1 ^ op2))
                 | ({XLEN{a.srl}} & (op1 >> shamt))
                 | ({XLEN{a.sra}} & XLEN'($signed(op1) >>> shamt))
                 | ({XLEN{a.or_}} & (op1 | op2))
                 | ({XLEN{a.and_}} & (op1 & op2))
                 | ({XLEN{a.lui}} & op2);

  assign taken = b.jal | b.jalr
               | (b.beq & eq) | (b.bne & ~eq)
               | (b.blt & lt) | (b.bge & ~lt)
               | (b.bltu & ltu) | (b.bgeu & ~ltu);

  // JALR target drops bit 0
  assign target = (op1_jp + op2_jp) & ~XLEN'(b.jalr);

  assign redirect_o    = pop_o & taken;
  assign redirect_pc_o = target;

  // Write back on the pop edge
  assign rf_we_o = pop_o & rd_wr_en;
  assign rf_wd_o = is_bjp ? sum : alu_res;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retire_valid_o <= 1'b0;
      ebreak_o       <= 1'b0;
      invalid_o      <= 1'b0;
    end else begin
      retire_valid_o <= pop_o;
      // Sticky until reset
      if (pop_o && a.ebreak) begin
        ebreak_o <= 1'b1;
      end
      if (pop_o && invalid) begin
        invalid_o <= 1'b1;
      end
    end
  end

  // Retire record
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      retire_pc_o      <= q_pc_i;
      retire_rd_we_o   <= rd_wr_en;
      retire_rd_idx_o  <= rf_wa_o;
      retire_rd_data_o <= rf_wd_o;
      retire_next_pc_o <= taken ? target : q_pc_i + XLEN'(4);
    end
  end

endmodule

/* rtl/core_top.sv */
module core_top import rv_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic [XLEN-1:0] wb_adr_o,
  input  logic [ILEN-1:0] wb_dat_i,
  input  logic            wb_ack_i,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic            retire_rd_we_o,
  output logic [4:0]      retire_rd_idx_o,
  output logic [XLEN-1:0] retire_rd_data_o,
  output logic [XLEN-1:0] retire_next_pc_o,
  output logic            ebreak_o,
  output logic            invalid_o
);

  // Fetch to queue
  logic push, room;
  logic [XLEN-1:0] push_pc;
  logic [ILEN-1:0] push_inst;
  // Queue to execute
  logic q_valid, pop;
  logic [XLEN-1:0] q_pc;
  logic [ILEN-1:0] q_inst;
  // Redirect and register file
  logic redirect, rf_we;
  logic [XLEN-1:0] redirect_pc, rf_rd1, rf_rd2, rf_wd;
  logic [4:0] rf_ra1, rf_ra2, rf_wa;

  ifu_fetch u_fetch (
    .clk_i, .arst_n_i,
    .q_room_i      (room),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .wb_dat_i, .wb_ack_i, .wb_cyc_o, .wb_stb_o, .wb_adr_o,
    .push_o        (push),
    .push_pc_o_unused_guard (),
    .push_pc_o     (push_pc),
    .push_inst_o   (push_inst)
  );

  inst_queue u_queue (
    .clk_i, .arst_n_i,
    .push_i      (push),
    .push_pc_i   (push_pc),
    .push_inst_i (push_inst),
    .pop_i       (pop),
    .flush_i     (redirect),
    .room_o      (room),
    .valid_o     (q_valid),
    .pc_o        (q_pc),
    .inst_o      (q_inst)
  );

  regfile u_regfile (
    .clk_i, .arst_n_i,
    .we_i  (rf_we),
    .wa_i  (rf_wa),
    .wd_i  (rf_wd),
    .ra1_i (rf_ra1),
    .ra2_i (rf_ra2),
    .rd1_o (rf_rd1),
    .rd2_o (rf_rd2)
  );

  exu_execute u_execute (
    .clk_i, .arst_n_i,
    .q_valid_i     (q_valid),
    .q_pc_i        (q_pc),
    .q_inst_i      (q_inst),
    .pop_o         (pop),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .retire_valid_o, .retire_pc_o, .retire_rd_we_o, .retire_rd_idx_o,
    .retire_rd_data_o, .retire_next_pc_o, .ebreak_o, .invalid_o,
    .rf_ra1_o (rf_ra1),
    .rf_ra2_o (rf_ra2),
    .rf_rd1_i (rf_rd1),
    .rf_rd2_i (rf_rd2),
    .rf_we_o  (rf_we),
    .rf_wa_o  (rf_wa),
    .rf_wd_o  (rf_wd)
  );

endmodule

/* test/tb_imem.sv */
module tb_imem import rv_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            cyc_i,
  input  logic            stb_i,
  input  logic [XLEN-1:0] adr_i,
  input  logic [ILEN-1:0] prog_i [64],
  output logic [ILEN-1:0] dat_o,
  output logic            ack_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Wait-state generator, fixed seed
  int seed = 32'h77fc_c4c9;
  int draw;
  logic       busy;
  logic [1:0] wait_cnt;

  // Word at a byte address, outside the program an undefined opcode
  function automatic logic [ILEN-1:0] word_at(logic [XLEN-1:0] adr);
    logic [XLEN-1:0] off;
    logic [XLEN-1:0] fold;
    off  = adr - RESET_PC;
    // Folded address fills the upper bits
    fold = adr ^ (adr >> 25) ^ (adr >> 50);
    if (off[XLEN-1:8] == '0) begin
      return prog_i[off[7:2]];
    end
    return {fold[24:0], 7'h00};
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o    <= 1'b0;
      dat_o    <= '0;
      busy     <= 1'b0;
      wait_cnt <= '0;
    end else if (ack_o) begin
      // Single-cycle ack, master closes the cycle
      ack_o <= 1'b0;
      busy  <= 1'b0;
    end else if (cyc_i && stb_i && !busy) begin
      draw = $random(seed);
      busy <= 1'b1;
      if (draw[1:0] == 2'd0) begin
        ack_o <= 1'b1;
        dat_o <= word_at(adr_i);
      end else begin
        wait_cnt <= draw[1:0];
      end
    end else if (busy) begin
      if (wait_cnt <= 2'd1) begin
        ack_o <= 1'b1;
        dat_o <= word_at(adr_i);
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

/* test/tb_core.sv */
module tb_core import rv_isa_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 5;
  localparam int QUIET_CYCLES = 20;
  localparam int HALT_NONE    = 0;
  localparam int HALT_EBREAK  = 1;
  localparam int HALT_INVALID = 2;

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  logic wb_cyc, wb_stb, wb_ack;
  logic [XLEN-1:0] wb_adr;
  logic [ILEN-1:0] wb_dat;
  logic retire_valid, retire_rd_we, ebreak, invalid;
  logic [4:0] retire_rd_idx;
  logic [XLEN-1:0] retire_pc, retire_rd_data, retire_next_pc;

  // Open bus cycle seen at the last falling edge
  logic            bus_open = 1'b0;
  logic [XLEN-1:0] bus_adr;

  // Program seen by the memory, and one image per run segment
  logic [ILEN-1:0] prog [64];
  logic [ILEN-1:0] prog1 [64];
  logic [ILEN-1:0] prog2 [64];

  // Expected retire stream
  string           e_name [$];
  logic [XLEN-1:0] e_pc [$];
  logic            e_we [$];
  logic [4:0]      e_idx [$];
  logic [XLEN-1:0] e_data [$];
  logic [XLEN-1:0] e_npc [$];
  int              e_halt [$];
  int seg1_n;
  int n_total = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  core_top DUT (
    .clk_i (clk), .arst_n_i (arst_n),
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_adr_o (wb_adr),
    .wb_dat_i (wb_dat), .wb_ack_i (wb_ack),
    .retire_valid_o (retire_valid), .retire_pc_o (retire_pc),
    .retire_rd_we_o (retire_rd_we), .retire_rd_idx_o (retire_rd_idx),
    .retire_rd_data_o (retire_rd_data), .retire_next_pc_o (retire_next_pc),
    .ebreak_o (ebreak), .invalid_o (invalid)
  );

  tb_imem imem (
    .clk_i (clk), .arst_n_i (arst_n),
    .cyc_i (wb_cyc), .stb_i (wb_stb), .adr_i (wb_adr),
    .prog_i (prog), .dat_o (wb_dat), .ack_o (wb_ack)
  );

  // Wishbone master keeps stb with cyc, and cyc and address until the ack
  always @(negedge clk) begin
    if (arst_n) begin
      assert (wb_stb === wb_cyc) else begin
        report_failure("wishbone strobe differs from the cycle signal");
      end
      assert (!bus_open || (wb_cyc === 1'b1 && wb_adr === bus_adr)) else begin
        report_failure("wishbone cycle or address changed before the ack");
      end
      bus_open <= wb_cyc && !wb_ack;
      bus_adr  <= wb_adr;
    end else begin
      bus_open <= 1'b0;
    end
  end

  // Instruction encoders
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // One expected retire, pc and next pc given as word indices
  task automatic expect_retire(string name, int w, logic we, logic [4:0] idx,
                               logic [XLEN-1:0] data, int npc_w, int halt);
    e_name.push_back(name);
    e_pc.push_back(RESET_PC + XLEN'(4 * w));
    e_we.push_back(we);
    e_idx.push_back(idx);
    e_data.push_back(data);
    e_npc.push_back(RESET_PC + XLEN'(4 * npc_w));
    e_halt.push_back(halt);
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_field(string test, string field, logic [XLEN-1:0] exp,
                             logic [XLEN-1:0] act);
    assert (act === exp) else begin
      report_failure($sformatf("mismatch %s %s expected %h actual %h",
                               test, field, exp, act));
    end
  endtask

  task automatic build_programs();
    for (int i = 0; i < 64; i++) begin
      // Undefined opcode everywhere else, so wrong-path words would show up
      prog1[i] = {7'(i), 18'h0, 7'h00};
      prog2[i] = {7'(i), 18'h0, 7'h00};
    end
    prog1[0]  = enc_i(12'd5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM);
    prog1[1]  = enc_i(12'hffd, 5'd0, 3'd0, 5'd2, OPC_OP_IMM);
    prog1[2]  = enc_r(F7_BASE, 5'd2, 5'd1, 3'd0, 5'd3);
    prog1[3]  = enc_r(F7_ALT, 5'd2, 5'd1, 3'd0, 5'd4);
    prog1[4]  = enc_i(12'd33, 5'd1, 3'd1, 5'd5, OPC_OP_IMM);
    prog1[5]  = enc_r(F7_BASE, 5'd1, 5'd2, 3'd1, 5'd6);
    prog1[6]  = enc_r(F7_BASE, 5'd1, 5'd2, 3'd2, 5'd7);
    prog1[7]  = enc_r(F7_BASE, 5'd1, 5'd2, 3'd3, 5'd8);
    prog1[8]  = enc_r(F7_BASE, 5'd2, 5'd1, 3'd4, 5'd9);
    prog1[9]  = enc_r(F7_BASE, 5'd1, 5'd2, 3'd5, 5'd10);
    prog1[10] = enc_r(F7_ALT, 5'd1, 5'd2, 3'd5, 5'd11);
    prog1[11] = enc_i(12'h404, 5'd6, 3'd5, 5'd12, OPC_OP_IMM);
    prog1[12] = enc_r(F7_BASE, 5'd2, 5'd1, 3'd6, 5'd13);
    prog1[13] = enc_r(F7_BASE, 5'd2, 5'd1, 3'd7, 5'd14);
    prog1[14] = enc_i(12'd7, 5'd1, 3'd0, 5'd0, OPC_OP_IMM);
    prog1[15] = enc_r(F7_BASE, 5'd1, 5'd0, 3'd0, 5'd15);
    prog1[16] = enc_u(20'h80000, 5'd16, OPC_LUI);
    prog1[17] = enc_u(20'h00001, 5'd17, OPC_AUIPC);
    prog1[18] = enc_j(21'd8, 5'd18);
    // Pairs of taken and not-taken branches, the skipped word stays undefined
    prog1[20] = enc_b(13'd8, 5'd15, 5'd1, 3'd0);
    prog1[22] = enc_b(13'd8, 5'd2, 5'd1, 3'd0);
    prog1[23] = enc_b(13'd8, 5'd2, 5'd1, 3'd1);
    prog1[25] = enc_b(13'd8, 5'd15, 5'd1, 3'd1);
    prog1[26] = enc_b(13'd8, 5'd1, 5'd2, 3'd4);
    prog1[28] = enc_b(13'd8, 5'd2, 5'd1, 3'd4);
    prog1[29] = enc_b(13'd8, 5'd2, 5'd1, 3'd5);
    prog1[31] = enc_b(13'd8, 5'd1, 5'd2, 3'd5);
    prog1[32] = enc_b(13'd8, 5'd2, 5'd1, 3'd6);
    prog1[34] = enc_b(13'd8, 5'd1, 5'd2, 3'd6);
    prog1[35] = enc_b(13'd8, 5'd1, 5'd2, 3'd7);
    prog1[37] = enc_b(13'd8, 5'd2, 5'd1, 3'd7);
    prog1[38] = enc_u(20'h0, 5'd20, OPC_AUIPC);
    // Odd offset, target drops bit 0
    prog1[39] = enc_i(12'd17, 5'd20, 3'd0, 5'd19, OPC_JALR);
    prog1[42] = 32'h0010_0073;
    prog2[0]  = enc_i(12'd1, 5'd0, 3'd0, 5'd1, OPC_OP_IMM);
    prog2[1]  = enc_r(F7_BASE, 5'd1, 5'd1, 3'd0, 5'd2);
    prog2[2]  = 32'hffff_ffff;
  endtask

  task automatic build_table();
    expect_retire("addi", 0, 1, 1, 64'd5, 1, HALT_NONE);
    expect_retire("addi_neg", 1, 1, 2, 64'hffff_ffff_ffff_fffd, 2, HALT_NONE);
    expect_retire("add", 2, 1, 3, 64'd2, 3, HALT_NONE);
    expect_retire("sub", 3, 1, 4, 64'd8, 4, HALT_NONE);
    expect_retire("slli", 4, 1, 5, 64'h0000_000a_0000_0000, 5, HALT_NONE);
    expect_retire("sll", 5, 1, 6, 64'hffff_ffff_ffff_ffa0, 6, HALT_NONE);
    expect_retire("slt", 6, 1, 7, 64'd1, 7, HALT_NONE);
    expect_retire("sltu", 7, 1, 8, 64'd0, 8, HALT_NONE);
    expect_retire("xor", 8, 1, 9, 64'hffff_ffff_ffff_fff8, 9, HALT_NONE);
    expect_retire("srl", 9, 1, 10, 64'h07ff_ffff_ffff_ffff, 10, HALT_NONE);
    expect_retire("sra", 10, 1, 11, 64'hffff_ffff_ffff_ffff, 11, HALT_NONE);
    expect_retire("srai", 11, 1, 12, 64'hffff_ffff_ffff_fffa, 12, HALT_NONE);
    expect_retire("or", 12, 1, 13, 64'hffff_ffff_ffff_fffd, 13, HALT_NONE);
    expect_retire("and", 13, 1, 14, 64'd5, 14, HALT_NONE);
    expect_retire("write_x0", 14, 0, 0, 64'd0, 15, HALT_NONE);
    expect_retire("read_x0", 15, 1, 15, 64'd5, 16, HALT_NONE);
    expect_retire("lui", 16, 1, 16, 64'hffff_ffff_8000_0000, 17, HALT_NONE);
    expect_retire("auipc", 17, 1, 17, 64'h0000_0000_8000_1044, 18, HALT_NONE);
    expect_retire("jal", 18, 1, 18, 64'h0000_0000_8000_004c, 20, HALT_NONE);
    expect_retire("beq_taken", 20, 0, 0, 64'd0, 22, HALT_NONE);
    expect_retire("beq_not", 22, 0, 0, 64'd0, 23, HALT_NONE);
    expect_retire("bne_taken", 23, 0, 0, 64'd0, 25, HALT_NONE);
    expect_retire("bne_not", 25, 0, 0, 64'd0, 26, HALT_NONE);
    expect_retire("blt_taken", 26, 0, 0, 64'd0, 28, HALT_NONE);
    expect_retire("blt_not", 28, 0, 0, 64'd0, 29, HALT_NONE);
    expect_retire("bge_taken", 29, 0, 0, 64'd0, 31, HALT_NONE);
    expect_retire("bge_not", 31, 0, 0, 64'd0, 32, HALT_NONE);
    expect_retire("bltu_taken", 32, 0, 0, 64'd0, 34, HALT_NONE);
    expect_retire("bltu_not", 34, 0, 0, 64'd0, 35, HALT_NONE);
    expect_retire("bgeu_taken", 35, 0, 0, 64'd0, 37, HALT_NONE);
    expect_retire("bgeu_not", 37, 0, 0, 64'd0, 38, HALT_NONE);
    expect_retire("auipc_base", 38, 1, 20, 64'h0000_0000_8000_0098, 39, HALT_NONE);
    expect_retire("jalr", 39, 1, 19, 64'h0000_0000_8000_00a0, 42, HALT_NONE);
    expect_retire("ebreak", 42, 0, 0, 64'd0, 43, HALT_EBREAK);
    seg1_n = e_name.size();
    // Second segment after a fresh reset
    expect_retire("seg2_addi", 0, 1, 1, 64'd1, 1, HALT_NONE);
    expect_retire("seg2_add", 1, 1, 2, 64'd2, 2, HALT_NONE);
    expect_retire("undefined", 2, 0, 0, 64'd0, 3, HALT_INVALID);
    n_total = e_name.size();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // Sampled on the falling edge, away from the registered outputs
  task automatic run_segment(int first, int last);
    for (int i = first; i < last; i++) begin
      @(negedge clk);
      while (!retire_valid) @(negedge clk);
      check_field(e_name[i], "pc", e_pc[i], retire_pc);
      check_field(e_name[i], "rd_we", XLEN'(e_we[i]), XLEN'(retire_rd_we));
      if (e_we[i]) begin
        check_field(e_name[i], "rd_idx", XLEN'(e_idx[i]), XLEN'(retire_rd_idx));
        check_field(e_name[i], "rd_data", e_data[i], retire_rd_data);
      end
      check_field(e_name[i], "next_pc", e_npc[i], retire_next_pc);
      check_field(e_name[i], "ebreak", XLEN'(e_halt[i] == HALT_EBREAK), XLEN'(ebreak));
      check_field(e_name[i], "invalid", XLEN'(e_halt[i] == HALT_INVALID), XLEN'(invalid));
    end
    // Halted core stays silent and keeps its halt flag
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (!retire_valid) else begin
        report_failure("instruction retired after the core halted");
      end
      assert (ebreak === (e_halt[last - 1] == HALT_EBREAK)
              && invalid === (e_halt[last - 1] == HALT_INVALID)) else begin
        report_failure("halt flag changed after the core halted");
      end
    end
  endtask

  initial begin
    build_programs();
    build_table();
    prog = prog1;
    apply_reset();
    run_segment(0, seg1_n);
    prog = prog2;
    apply_reset();
    run_segment(seg1_n, n_total);
    $display("=== PASS ===");
    $finish;
  end

  // Budget of cycles per table entry plus resets and quiet windows
  initial begin
    wait (n_total != 0);
    #(n_total * 20 * CLK_PERIOD + 2 * (RST_CYCLES + QUIET_CYCLES + 4) * CLK_PERIOD);
    report_failure("timeout, the core stopped retiring");
  end

endmodule

/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/exu_pkg.sv
rtl/ifu_fetch.sv
rtl/inst_queue.sv
rtl/idu_decode.sv
rtl/regfile.sv
rtl/exu_execute.sv
rtl/core_top.sv
test/tb_imem.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core \
  -Mdir obj_dir -f filelist.f

./obj_dir/Vtb_core > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
  exit 0
fi
exit 1
